// ==== logic/wbi_pkg.sv ====
// Wishbone interconnect shared types
package wbi_pkg;

  // ----------------------------------------
  // Bus field types
  // ----------------------------------------

  // Data word on both read and write paths
  typedef logic [31:0] wb_data_t;

  // Byte address as issued by a master
  typedef logic [31:0] wb_addr_t;

  // One select bit per byte lane
  typedef logic [3:0] wb_sel_t;

  // One bit per master, bit 0 is master 0
  typedef logic [2:0] wb_mid_t;

  // Target slave id from the address decode
  typedef logic [1:0] wb_tid_t;

  // ----------------------------------------
  // Target encodings
  // ----------------------------------------

  // Serial flash memory and its register page
  localparam wb_tid_t TID_FLASH  = 2'd0;
  // UART and the other low speed peripherals
  localparam wb_tid_t TID_UART   = 2'd1;
  // Pin mux and global registers
  localparam wb_tid_t TID_PINMUX = 2'd2;

  // ----------------------------------------
  // Address pages, upper 16 address bits
  // ----------------------------------------

  // 0x0000_0000 to 0x0FFF_FFFF is flash memory and needs no page
  localparam logic [15:0] PAGE_FLASH_REG = 16'h1000;
  localparam logic [15:0] PAGE_UART      = 16'h1001;
  localparam logic [15:0] PAGE_PINMUX    = 16'h1002;

  // ----------------------------------------
  // Narrow slave address widths
  // ----------------------------------------

  // UART block decodes a 512 byte window
  localparam int UART_ADR_W   = 9;
  // Pin mux decodes a 256 byte window
  localparam int PINMUX_ADR_W = 8;

endpackage

// ==== logic/wbi_master_port.sv ====
// Master side decode and return mux
module wbi_master_port (
  input  logic              clk_i,
  // Request from the master
  input  wbi_pkg::wb_addr_t adr_i,
  input  logic              stb_i,
  // Ack of each slave port towards this master
  input  logic [2:0]        s_ack_i,
  input  wbi_pkg::wb_data_t s0_dat_i,
  input  wbi_pkg::wb_data_t s1_dat_i,
  input  wbi_pkg::wb_data_t s2_dat_i,
  // Strobe steered to the decoded slave port
  output logic [2:0]        req_o,
  // Response back to the master
  output logic              ack_o,
  output wbi_pkg::wb_data_t dat_o
);

  wbi_pkg::wb_tid_t tid;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------

  // Flash memory range and unmapped pages all fall to the flash slave
  always_comb begin
    case (adr_i[31:16])
      wbi_pkg::PAGE_FLASH_REG: tid = wbi_pkg::TID_FLASH;
      wbi_pkg::PAGE_UART:      tid = wbi_pkg::TID_UART;
      wbi_pkg::PAGE_PINMUX:    tid = wbi_pkg::TID_PINMUX;
      default:                 tid = wbi_pkg::TID_FLASH;
    endcase
  end

  // ----------------------------------------
  // Request steer and response select
  // ----------------------------------------

  always_comb begin
    req_o = 3'b000;
    case (tid)
      wbi_pkg::TID_UART: begin
        // Peripheral page
        req_o[1] = stb_i;
        ack_o    = s_ack_i[1];
        dat_o    = s1_dat_i;
      end
      wbi_pkg::TID_PINMUX: begin
        req_o[2] = stb_i;
        ack_o    = s_ack_i[2];
        dat_o    = s2_dat_i;
      end
      default: begin
        // Flash memory, flash registers and anything unmapped
        req_o[0] = stb_i;
        ack_o    = s_ack_i[0];
        dat_o    = s0_dat_i;
      end
    endcase
  end

  // At most one slave port may see this master at a time
  a_req_onehot: assert property (@(posedge clk_i) $onehot0(req_o))
    else $error("master request steered to more than one slave");

endmodule

// ==== logic/wbi_rr_arbiter.sv ====
// Round robin slave port arbiter
module wbi_rr_arbiter (
  input  logic             clk_i,
  input  logic             reset_i,
  // Strobe of each master aimed at this slave
  input  wbi_pkg::wb_mid_t req_i,
  // Bus cycle of each master
  input  wbi_pkg::wb_mid_t cyc_i,
  output wbi_pkg::wb_mid_t gnt_o,
  output logic             busy_o
);

  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_t;

  arb_state_t       state_q;
  wbi_pkg::wb_mid_t gnt_q;
  wbi_pkg::wb_mid_t last_q;
  wbi_pkg::wb_mid_t req_v;
  wbi_pkg::wb_mid_t nxt_gnt;
  logic             hold;

  // Strobe only counts inside a bus cycle
  assign req_v = req_i & cyc_i;
  // Owner keeps the port while its request stays up
  assign hold  = |(gnt_q & req_v);

  // ----------------------------------------
  // Next grant, rotating after last owner
  // ----------------------------------------

  always_comb begin
    nxt_gnt = 3'b000;
    case (last_q)
      3'b001: begin
        if (req_v[1]) nxt_gnt = 3'b010;
        else if (req_v[2]) nxt_gnt = 3'b100;
        else if (req_v[0]) nxt_gnt = 3'b001;
      end
      3'b010: begin
        if (req_v[2]) nxt_gnt = 3'b100;
        else if (req_v[0]) nxt_gnt = 3'b001;
        else if (req_v[1]) nxt_gnt = 3'b010;
      end
      default: begin
        // Last owner was master 2, or nobody since reset
        if (req_v[0]) nxt_gnt = 3'b001;
        else if (req_v[1]) nxt_gnt = 3'b010;
        else if (req_v[2]) nxt_gnt = 3'b100;
      end
    endcase
  end

  // ----------------------------------------
  // Grant FSM
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ARB_IDLE;
      gnt_q   <= 3'b000;
      // Master 0 wins first after reset
      last_q  <= 3'b100;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (|req_v) begin
            state_q <= ARB_BUSY;
            gnt_q   <= nxt_gnt;
            last_q  <= nxt_gnt;
          end
        end
        ARB_BUSY: begin
          if (!hold) begin
            // Hand over on the release edge if someone is waiting
            if (|req_v) begin
              gnt_q  <= nxt_gnt;
              last_q <= nxt_gnt;
            end else begin
              state_q <= ARB_IDLE;
              gnt_q   <= 3'b000;
            end
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  assign gnt_o  = gnt_q;
  assign busy_o = (state_q == ARB_BUSY);

  a_gnt_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    busy_o |-> $onehot(gnt_o));
  a_gnt_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !busy_o |-> (gnt_o == 3'b000));

endmodule

// ==== logic/wbi_slave_port.sv ====
// Slave side request mux and ack return
module wbi_slave_port (
  input  logic              clk_i,
  input  logic              reset_i,
  // Steered strobes and raw cycles, one bit per master
  input  wbi_pkg::wb_mid_t  req_i,
  input  wbi_pkg::wb_mid_t  m_cyc_i,
  // Master 0 request fields
  input  logic              m0_we_i,
  input  wbi_pkg::wb_addr_t m0_adr_i,
  input  wbi_pkg::wb_sel_t  m0_sel_i,
  input  wbi_pkg::wb_data_t m0_dat_i,
  // Master 1 request fields
  input  logic              m1_we_i,
  input  wbi_pkg::wb_addr_t m1_adr_i,
  input  wbi_pkg::wb_sel_t  m1_sel_i,
  input  wbi_pkg::wb_data_t m1_dat_i,
  // Master 2 request fields
  input  logic              m2_we_i,
  input  wbi_pkg::wb_addr_t m2_adr_i,
  input  wbi_pkg::wb_sel_t  m2_sel_i,
  input  wbi_pkg::wb_data_t m2_dat_i,
  // Slave response
  input  wbi_pkg::wb_data_t s_dat_i,
  input  logic              s_ack_i,
  // Slave request
  output logic              s_cyc_o,
  output logic              s_stb_o,
  output logic              s_we_o,
  output wbi_pkg::wb_addr_t s_adr_o,
  output wbi_pkg::wb_sel_t  s_sel_o,
  output wbi_pkg::wb_data_t s_dat_o,
  // Response towards the masters
  output wbi_pkg::wb_mid_t  m_ack_o,
  output wbi_pkg::wb_data_t m_dat_o
);

  wbi_pkg::wb_mid_t gnt;
  logic             busy;

  wbi_rr_arbiter u_arb (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .cyc_i   (m_cyc_i),
    .gnt_o   (gnt),
    .busy_o  (busy)
  );

  // ----------------------------------------
  // Granted master to slave
  // ----------------------------------------

  assign s_cyc_o = busy & |(gnt & m_cyc_i);
  // Stb follows the owner's steered strobe so it drops right after ack
  assign s_stb_o = |(gnt & req_i & m_cyc_i);

  always_comb begin
    case (gnt)
      3'b001: begin
        s_we_o  = m0_we_i;
        s_adr_o = m0_adr_i;
        s_sel_o = m0_sel_i;
        s_dat_o = m0_dat_i;
      end
      3'b010: begin
        s_we_o  = m1_we_i;
        s_adr_o = m1_adr_i;
        s_sel_o = m1_sel_i;
        s_dat_o = m1_dat_i;
      end
      3'b100: begin
        s_we_o  = m2_we_i;
        s_adr_o = m2_adr_i;
        s_sel_o = m2_sel_i;
        s_dat_o = m2_dat_i;
      end
      default: begin
        // Port idle, park the fields at zero
        s_we_o  = 1'b0;
        s_adr_o = '0;
        s_sel_o = '0;
        s_dat_o = '0;
      end
    endcase
  end

  // ----------------------------------------
  // Response return
  // ----------------------------------------

  // Only the owner sees the ack
  assign m_ack_o = gnt & {3{s_ack_i}};
  // Read data is shared, the master side picks by its own decode
  assign m_dat_o = s_dat_i;

  // Slave may only answer inside a cycle it was given
  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    s_ack_i |-> s_cyc_o);

endmodule

// ==== logic/wb_interconnect.sv ====
// Wishbone three by three interconnect
module wb_interconnect (
  input  logic                                clk_i,
  input  logic                                reset_i,
  // Master 0
  input  wbi_pkg::wb_data_t                   m0_wbd_dat_i,
  input  wbi_pkg::wb_addr_t                   m0_wbd_adr_i,
  input  wbi_pkg::wb_sel_t                    m0_wbd_sel_i,
  input  logic                                m0_wbd_we_i,
  input  logic                                m0_wbd_cyc_i,
  input  logic                                m0_wbd_stb_i,
  output wbi_pkg::wb_data_t                   m0_wbd_dat_o,
  output logic                                m0_wbd_ack_o,
  // Master 1
  input  wbi_pkg::wb_data_t                   m1_wbd_dat_i,
  input  wbi_pkg::wb_addr_t                   m1_wbd_adr_i,
  input  wbi_pkg::wb_sel_t                    m1_wbd_sel_i,
  input  logic                                m1_wbd_we_i,
  input  logic                                m1_wbd_cyc_i,
  input  logic                                m1_wbd_stb_i,
  output wbi_pkg::wb_data_t                   m1_wbd_dat_o,
  output logic                                m1_wbd_ack_o,
  // Master 2
  input  wbi_pkg::wb_data_t                   m2_wbd_dat_i,
  input  wbi_pkg::wb_addr_t                   m2_wbd_adr_i,
  input  wbi_pkg::wb_sel_t                    m2_wbd_sel_i,
  input  logic                                m2_wbd_we_i,
  input  logic                                m2_wbd_cyc_i,
  input  logic                                m2_wbd_stb_i,
  output wbi_pkg::wb_data_t                   m2_wbd_dat_o,
  output logic                                m2_wbd_ack_o,
  // Slave 0, flash memory and registers
  input  wbi_pkg::wb_data_t                   s0_wbd_dat_i,
  input  logic                                s0_wbd_ack_i,
  output wbi_pkg::wb_data_t                   s0_wbd_dat_o,
  output wbi_pkg::wb_addr_t                   s0_wbd_adr_o,
  output wbi_pkg::wb_sel_t                    s0_wbd_sel_o,
  output logic                                s0_wbd_we_o,
  output logic                                s0_wbd_cyc_o,
  output logic                                s0_wbd_stb_o,
  // Slave 1, UART and peripherals
  input  wbi_pkg::wb_data_t                   s1_wbd_dat_i,
  input  logic                                s1_wbd_ack_i,
  output wbi_pkg::wb_data_t                   s1_wbd_dat_o,
  output logic [wbi_pkg::UART_ADR_W-1:0]      s1_wbd_adr_o,
  output wbi_pkg::wb_sel_t                    s1_wbd_sel_o,
  output logic                                s1_wbd_we_o,
  output logic                                s1_wbd_cyc_o,
  output logic                                s1_wbd_stb_o,
  // Slave 2, pin mux
  input  wbi_pkg::wb_data_t                   s2_wbd_dat_i,
  input  logic                                s2_wbd_ack_i,
  output wbi_pkg::wb_data_t                   s2_wbd_dat_o,
  output logic [wbi_pkg::PINMUX_ADR_W-1:0]    s2_wbd_adr_o,
  output wbi_pkg::wb_sel_t                    s2_wbd_sel_o,
  output logic                                s2_wbd_we_o,
  output logic                                s2_wbd_cyc_o,
  output logic                                s2_wbd_stb_o
);

  // Per master strobe steered by slave index
  logic [2:0]        m0_req;
  logic [2:0]        m1_req;
  logic [2:0]        m2_req;
  // Per slave ack by master index, and read data
  wbi_pkg::wb_mid_t  s0_mack;
  wbi_pkg::wb_mid_t  s1_mack;
  wbi_pkg::wb_mid_t  s2_mack;
  wbi_pkg::wb_data_t s0_mdat;
  wbi_pkg::wb_data_t s1_mdat;
  wbi_pkg::wb_data_t s2_mdat;
  // Full width addresses before truncation
  wbi_pkg::wb_addr_t s1_adr;
  wbi_pkg::wb_addr_t s2_adr;
  wbi_pkg::wb_mid_t  m_cyc;

  assign m_cyc = {m2_wbd_cyc_i, m1_wbd_cyc_i, m0_wbd_cyc_i};

  // ----------------------------------------
  // Master ports
  // ----------------------------------------

  wbi_master_port u_m0 (
    .clk_i    (clk_i),
    .adr_i    (m0_wbd_adr_i),
    .stb_i    (m0_wbd_stb_i),
    .s_ack_i  ({s2_mack[0], s1_mack[0], s0_mack[0]}),
    .s0_dat_i (s0_mdat),
    .s1_dat_i (s1_mdat),
    .s2_dat_i (s2_mdat),
    .req_o    (m0_req),
    .ack_o    (m0_wbd_ack_o),
    .dat_o    (m0_wbd_dat_o)
  );

  wbi_master_port u_m1 (
    .clk_i    (clk_i),
    .adr_i    (m1_wbd_adr_i),
    .stb_i    (m1_wbd_stb_i),
    .s_ack_i  ({s2_mack[1], s1_mack[1], s0_mack[1]}),
    .s0_dat_i (s0_mdat),
    .s1_dat_i (s1_mdat),
    .s2_dat_i (s2_mdat),
    .req_o    (m1_req),
    .ack_o    (m1_wbd_ack_o),
    .dat_o    (m1_wbd_dat_o)
  );

  wbi_master_port u_m2 (
    .clk_i    (clk_i),
    .adr_i    (m2_wbd_adr_i),
    .stb_i    (m2_wbd_stb_i),
    .s_ack_i  ({s2_mack[2], s1_mack[2], s0_mack[2]}),
    .s0_dat_i (s0_mdat),
    .s1_dat_i (s1_mdat),
    .s2_dat_i (s2_mdat),
    .req_o    (m2_req),
    .ack_o    (m2_wbd_ack_o),
    .dat_o    (m2_wbd_dat_o)
  );

  // ----------------------------------------
  // Slave ports
  // ----------------------------------------

  wbi_slave_port u_s0 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    ({m2_req[0], m1_req[0], m0_req[0]}),
    .m_cyc_i  (m_cyc),
    .m0_we_i  (m0_wbd_we_i),
    .m0_adr_i (m0_wbd_adr_i),
    .m0_sel_i (m0_wbd_sel_i),
    .m0_dat_i (m0_wbd_dat_i),
    .m1_we_i  (m1_wbd_we_i),
    .m1_adr_i (m1_wbd_adr_i),
    .m1_sel_i (m1_wbd_sel_i),
    .m1_dat_i (m1_wbd_dat_i),
    .m2_we_i  (m2_wbd_we_i),
    .m2_adr_i (m2_wbd_adr_i),
    .m2_sel_i (m2_wbd_sel_i),
    .m2_dat_i (m2_wbd_dat_i),
    .s_dat_i  (s0_wbd_dat_i),
    .s_ack_i  (s0_wbd_ack_i),
    .s_cyc_o  (s0_wbd_cyc_o),
    .s_stb_o  (s0_wbd_stb_o),
    .s_we_o   (s0_wbd_we_o),
    .s_adr_o  (s0_wbd_adr_o),
    .s_sel_o  (s0_wbd_sel_o),
    .s_dat_o  (s0_wbd_dat_o),
    .m_ack_o  (s0_mack),
    .m_dat_o  (s0_mdat)
  );

  wbi_slave_port u_s1 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    ({m2_req[1], m1_req[1], m0_req[1]}),
    .m_cyc_i  (m_cyc),
    .m0_we_i  (m0_wbd_we_i),
    .m0_adr_i (m0_wbd_adr_i),
    .m0_sel_i (m0_wbd_sel_i),
    .m0_dat_i (m0_wbd_dat_i),
    .m1_we_i  (m1_wbd_we_i),
    .m1_adr_i (m1_wbd_adr_i),
    .m1_sel_i (m1_wbd_sel_i),
    .m1_dat_i (m1_wbd_dat_i),
    .m2_we_i  (m2_wbd_we_i),
    .m2_adr_i (m2_wbd_adr_i),
    .m2_sel_i (m2_wbd_sel_i),
    .m2_dat_i (m2_wbd_dat_i),
    .s_dat_i  (s1_wbd_dat_i),
    .s_ack_i  (s1_wbd_ack_i),
    .s_cyc_o  (s1_wbd_cyc_o),
    .s_stb_o  (s1_wbd_stb_o),
    .s_we_o   (s1_wbd_we_o),
    .s_adr_o  (s1_adr),
    .s_sel_o  (s1_wbd_sel_o),
    .s_dat_o  (s1_wbd_dat_o),
    .m_ack_o  (s1_mack),
    .m_dat_o  (s1_mdat)
  );

  wbi_slave_port u_s2 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    ({m2_req[2], m1_req[2], m0_req[2]}),
    .m_cyc_i  (m_cyc),
    .m0_we_i  (m0_wbd_we_i),
    .m0_adr_i (m0_wbd_adr_i),
    .m0_sel_i (m0_wbd_sel_i),
    .m0_dat_i (m0_wbd_dat_i),
    .m1_we_i  (m1_wbd_we_i),
    .m1_adr_i (m1_wbd_adr_i),
    .m1_sel_i (m1_wbd_sel_i),
    .m1_dat_i (m1_wbd_dat_i),
    .m2_we_i  (m2_wbd_we_i),
    .m2_adr_i (m2_wbd_adr_i),
    .m2_sel_i (m2_wbd_sel_i),
    .m2_dat_i (m2_wbd_dat_i),
    .s_dat_i  (s2_wbd_dat_i),
    .s_ack_i  (s2_wbd_ack_i),
    .s_cyc_o  (s2_wbd_cyc_o),
    .s_stb_o  (s2_wbd_stb_o),
    .s_we_o   (s2_wbd_we_o),
    .s_adr_o  (s2_adr),
    .s_sel_o  (s2_wbd_sel_o),
    .s_dat_o  (s2_wbd_dat_o),
    .m_ack_o  (s2_mack),
    .m_dat_o  (s2_mdat)
  );

  // Peripheral slaves decode only their low address bits
  assign s1_wbd_adr_o = s1_adr[wbi_pkg::UART_ADR_W-1:0];
  assign s2_wbd_adr_o = s2_adr[wbi_pkg::PINMUX_ADR_W-1:0];

endmodule

// ==== dv/wbi_slave_model.sv ====
// Wishbone memory slave model
module wbi_slave_model #(
  parameter int ADR_W   = 32,
  parameter int ACK_DLY = 1
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              cyc_i,
  input  logic              stb_i,
  input  logic              we_i,
  input  logic [ADR_W-1:0]  adr_i,
  input  wbi_pkg::wb_sel_t  sel_i,
  input  wbi_pkg::wb_data_t dat_i,
  output wbi_pkg::wb_data_t dat_o,
  output logic              ack_o,
  // Accesses acked so far and the address of the latest one
  output logic [31:0]       hits_o,
  output wbi_pkg::wb_addr_t last_adr_o
);
  timeunit 1ns;
  timeprecision 100ps;

  wbi_pkg::wb_data_t mem [1024];
  logic [9:0]        idx;
  int                cnt;

  // Word index, upper address bits alias
  assign idx = 10'(adr_i >> 2);

  // Fill depends on the full word index
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'hC0DE_0000 | i;
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_o      <= 1'b0;
      cnt        <= 0;
      hits_o     <= '0;
      last_adr_o <= '0;
      dat_o      <= '0;
    end else if (ack_o) begin
      // Single cycle ack, then wait for the next strobe
      ack_o <= 1'b0;
      cnt   <= 0;
    end else if (cyc_i && stb_i) begin
      if (cnt == ACK_DLY - 1) begin
        ack_o      <= 1'b1;
        hits_o     <= hits_o + 1;
        last_adr_o <= 32'(adr_i);
        dat_o      <= mem[idx];
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end else begin
        cnt <= cnt + 1;
      end
    end else begin
      cnt <= 0;
    end
  end

endmodule

// ==== dv/tb_wb_interconnect.sv ====
// Wishbone interconnect testbench
module tb_wb_interconnect;
  timeunit 1ns;
  timeprecision 100ps;

  // 3 masters x 5 regions, each a write then a read back
  localparam int N_TBL     = 30;
  // Table, contention rounds, parallel rounds
  localparam int N_XFER    = N_TBL + 36 + 18;
  localparam int CYC_LIMIT = N_XFER * 20;

  logic clk;
  logic reset;
  int   cycles = 0;

  // Master side
  logic              m_cyc  [3];
  logic              m_stb  [3];
  logic              m_we   [3];
  logic              m_ack  [3];
  wbi_pkg::wb_addr_t m_adr  [3];
  wbi_pkg::wb_sel_t  m_sel  [3];
  wbi_pkg::wb_data_t m_wdat [3];
  wbi_pkg::wb_data_t m_rdat [3];

  // Slave side
  logic              s_cyc  [3];
  logic              s_stb  [3];
  logic              s_we   [3];
  logic              s_ack  [3];
  wbi_pkg::wb_sel_t  s_sel  [3];
  wbi_pkg::wb_data_t s_wdat [3];
  wbi_pkg::wb_data_t s_rdat [3];
  wbi_pkg::wb_addr_t s0_adr;
  logic [wbi_pkg::UART_ADR_W-1:0]   s1_adr;
  logic [wbi_pkg::PINMUX_ADR_W-1:0] s2_adr;
  logic [31:0]       hits     [3];
  logic [31:0]       hit_snap [3];
  wbi_pkg::wb_addr_t last_adr [3];

  // ----------------------------------------
  // Transaction table
  // ----------------------------------------

  int                t_mst  [N_TBL];
  logic              t_we   [N_TBL];
  wbi_pkg::wb_addr_t t_adr  [N_TBL];
  wbi_pkg::wb_data_t t_dat  [N_TBL];
  wbi_pkg::wb_data_t t_exp  [N_TBL];
  wbi_pkg::wb_tid_t  t_tid  [N_TBL];
  wbi_pkg::wb_addr_t t_sadr [N_TBL];

  // Flash memory, flash regs, UART, pin mux, unmapped
  wbi_pkg::wb_addr_t reg_base [5] = '{32'h0000_0100, 32'h1000_0040, 32'h1001_F384,
                                      32'h1002_A5C0, 32'h2000_0200};
  wbi_pkg::wb_tid_t  reg_tid  [5] = '{2'd0, 2'd0, 2'd1, 2'd2, 2'd0};
  // Address bits each slave actually receives
  wbi_pkg::wb_addr_t reg_mask [5] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_01FF,
                                      32'h0000_00FF, 32'hFFFF_FFFF};
  // Scratch areas per slave for the concurrent phases
  wbi_pkg::wb_addr_t pool_base [3] = '{32'h0000_0800, 32'h1001_0100, 32'h1002_0040};

  // Reference round robin state, last master served per slave
  int                last_gnt [3] = '{2, 2, 2};
  int                done_q [$];
  wbi_pkg::wb_addr_t race_adr  [3];
  wbi_pkg::wb_data_t race_wdat [3];
  wbi_pkg::wb_data_t race_rdat [3];

  always #2 clk = ~clk;

  // ----------------------------------------
  // DUT and slave models
  // ----------------------------------------

  wb_interconnect uut (
    .clk_i (clk), .reset_i (reset),
    .m0_wbd_dat_i (m_wdat[0]), .m0_wbd_adr_i (m_adr[0]), .m0_wbd_sel_i (m_sel[0]),
    .m0_wbd_we_i  (m_we[0]),   .m0_wbd_cyc_i (m_cyc[0]), .m0_wbd_stb_i (m_stb[0]),
    .m0_wbd_dat_o (m_rdat[0]), .m0_wbd_ack_o (m_ack[0]),
    .m1_wbd_dat_i (m_wdat[1]), .m1_wbd_adr_i (m_adr[1]), .m1_wbd_sel_i (m_sel[1]),
    .m1_wbd_we_i  (m_we[1]),   .m1_wbd_cyc_i (m_cyc[1]), .m1_wbd_stb_i (m_stb[1]),
    .m1_wbd_dat_o (m_rdat[1]), .m1_wbd_ack_o (m_ack[1]),
    .m2_wbd_dat_i (m_wdat[2]), .m2_wbd_adr_i (m_adr[2]), .m2_wbd_sel_i (m_sel[2]),
    .m2_wbd_we_i  (m_we[2]),   .m2_wbd_cyc_i (m_cyc[2]), .m2_wbd_stb_i (m_stb[2]),
    .m2_wbd_dat_o (m_rdat[2]), .m2_wbd_ack_o (m_ack[2]),
    .s0_wbd_dat_i (s_rdat[0]), .s0_wbd_ack_i (s_ack[0]), .s0_wbd_dat_o (s_wdat[0]),
    .s0_wbd_adr_o (s0_adr),    .s0_wbd_sel_o (s_sel[0]), .s0_wbd_we_o  (s_we[0]),
    .s0_wbd_cyc_o (s_cyc[0]),  .s0_wbd_stb_o (s_stb[0]),
    .s1_wbd_dat_i (s_rdat[1]), .s1_wbd_ack_i (s_ack[1]), .s1_wbd_dat_o (s_wdat[1]),
    .s1_wbd_adr_o (s1_adr),    .s1_wbd_sel_o (s_sel[1]), .s1_wbd_we_o  (s_we[1]),
    .s1_wbd_cyc_o (s_cyc[1]),  .s1_wbd_stb_o (s_stb[1]),
    .s2_wbd_dat_i (s_rdat[2]), .s2_wbd_ack_i (s_ack[2]), .s2_wbd_dat_o (s_wdat[2]),
    .s2_wbd_adr_o (s2_adr),    .s2_wbd_sel_o (s_sel[2]), .s2_wbd_we_o  (s_we[2]),
    .s2_wbd_cyc_o (s_cyc[2]),  .s2_wbd_stb_o (s_stb[2])
  );

  // Each slave answers with its own delay
  wbi_slave_model #(.ADR_W(32), .ACK_DLY(1)) u_slv0 (
    .clk_i (clk), .reset_i (reset), .cyc_i (s_cyc[0]), .stb_i (s_stb[0]),
    .we_i (s_we[0]), .adr_i (s0_adr), .sel_i (s_sel[0]), .dat_i (s_wdat[0]),
    .dat_o (s_rdat[0]), .ack_o (s_ack[0]), .hits_o (hits[0]), .last_adr_o (last_adr[0])
  );
  wbi_slave_model #(.ADR_W(wbi_pkg::UART_ADR_W), .ACK_DLY(2)) u_slv1 (
    .clk_i (clk), .reset_i (reset), .cyc_i (s_cyc[1]), .stb_i (s_stb[1]),
    .we_i (s_we[1]), .adr_i (s1_adr), .sel_i (s_sel[1]), .dat_i (s_wdat[1]),
    .dat_o (s_rdat[1]), .ack_o (s_ack[1]), .hits_o (hits[1]), .last_adr_o (last_adr[1])
  );
  wbi_slave_model #(.ADR_W(wbi_pkg::PINMUX_ADR_W), .ACK_DLY(3)) u_slv2 (
    .clk_i (clk), .reset_i (reset), .cyc_i (s_cyc[2]), .stb_i (s_stb[2]),
    .we_i (s_we[2]), .adr_i (s2_adr), .sel_i (s_sel[2]), .dat_i (s_wdat[2]),
    .dat_o (s_rdat[2]), .ack_o (s_ack[2]), .hits_o (hits[2]), .last_adr_o (last_adr[2])
  );

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input wbi_pkg::wb_data_t exp,
                            input wbi_pkg::wb_data_t act);
    if (exp !== act) abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input wbi_pkg::wb_addr_t exp,
                            input wbi_pkg::wb_addr_t act);
    if (exp !== act) abort_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_tid(input string name, input wbi_pkg::wb_tid_t exp,
                           input wbi_pkg::wb_tid_t act);
    if (exp !== act) abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_mid(input string name, input wbi_pkg::wb_mid_t exp,
                           input wbi_pkg::wb_mid_t act);
    if (exp !== act) abort_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
  endtask

  function automatic wbi_pkg::wb_mid_t one_hot(input int m);
    one_hot = 3'b001 << m;
  endfunction

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYC_LIMIT) begin
      abort_run($sformatf("Run did not finish within %0d cycles", CYC_LIMIT));
    end
  end

  // ----------------------------------------
  // Master driver and helpers
  // ----------------------------------------

  // One transfer, held until ack, stb then cyc dropped on later falling edges
  task automatic do_xfer(input int m, input logic we, input wbi_pkg::wb_addr_t adr,
                         input wbi_pkg::wb_data_t wdat, output wbi_pkg::wb_data_t rdat);
    @(negedge clk);
    m_adr[m]  = adr;
    m_we[m]   = we;
    m_sel[m]  = 4'hF;
    m_wdat[m] = wdat;
    m_cyc[m]  = 1'b1;
    m_stb[m]  = 1'b1;
    @(negedge clk);
    while (!m_ack[m]) begin
      @(negedge clk);
    end
    rdat     = m_rdat[m];
    m_stb[m] = 1'b0;
    @(negedge clk);
    m_cyc[m] = 1'b0;
    m_we[m]  = 1'b0;
  endtask

  task automatic xfer_logged(input int m, input logic we);
    wbi_pkg::wb_data_t rd;
    do_xfer(m, we, race_adr[m], race_wdat[m], rd);
    race_rdat[m] = rd;
    done_q.push_back(m);
  endtask

  task automatic take_snapshot();
    for (int s = 0; s < 3; s++) begin
      hit_snap[s] = hits[s];
    end
  endtask

  // Which single slave took the last access
  task automatic find_target(output wbi_pkg::wb_tid_t tid);
    int n;
    n = 0;
    tid = '0;
    for (int s = 0; s < 3; s++) begin
      if (hits[s] != hit_snap[s]) begin
        n++;
        tid = wbi_pkg::wb_tid_t'(s);
      end
    end
    if (n != 1) abort_run($sformatf("One access was seen on %0d slaves", n));
  endtask

  task automatic build_table();
    int i;
    for (int m = 0; m < 3; m++) begin
      for (int r = 0; r < 5; r++) begin
        i = 2 * (m * 5 + r);
        t_mst[i]   = m;
        t_we[i]    = 1'b1;
        t_adr[i]   = reg_base[r] + m * 8;
        t_dat[i]   = $urandom;
        t_exp[i]   = '0;
        t_tid[i]   = reg_tid[r];
        t_sadr[i]  = t_adr[i] & reg_mask[r];
        // Read back entry expects the data just written
        t_mst[i+1]  = m;
        t_we[i+1]   = 1'b0;
        t_adr[i+1]  = t_adr[i];
        t_dat[i+1]  = '0;
        t_exp[i+1]  = t_dat[i];
        t_tid[i+1]  = t_tid[i];
        t_sadr[i+1] = t_sadr[i];
      end
    end
  endtask

  // All three masters on slave t at once, grants must rotate
  task automatic race_all(input int t, input logic we);
    int exp_m;
    take_snapshot();
    done_q.delete();
    fork
      xfer_logged(0, we);
      xfer_logged(1, we);
      xfer_logged(2, we);
    join
    for (int k = 0; k < 3; k++) begin
      exp_m = (last_gnt[t] + 1 + k) % 3;
      check_mid($sformatf("slave %0d grant %0d", t, k), one_hot(exp_m), one_hot(done_q[k]));
    end
    last_gnt[t] = done_q[2];
    for (int o = 0; o < 3; o++) begin
      if (o != t && hits[o] != hit_snap[o]) begin
        abort_run($sformatf("Contention on slave %0d leaked onto slave %0d", t, o));
      end
    end
    if (hits[t] != hit_snap[t] + 3) abort_run($sformatf("Slave %0d lost a transfer", t));
  endtask

  task automatic contend(input int t, input int round);
    for (int m = 0; m < 3; m++) begin
      race_adr[m]  = pool_base[t] + round * 32'h20 + m * 4;
      race_wdat[m] = $urandom;
    end
    race_all(t, 1'b1);
    race_all(t, 1'b0);
    for (int m = 0; m < 3; m++) begin
      check_data($sformatf("contend s%0d r%0d m%0d", t, round, m), race_wdat[m], race_rdat[m]);
    end
  endtask

  // Each master on its own slave, all running together
  task automatic parallel_round(input int k);
    for (int m = 0; m < 3; m++) begin
      race_adr[m]  = pool_base[(m + k) % 3] + 32'h80 + m * 4;
      race_wdat[m] = $urandom;
    end
    take_snapshot();
    fork
      xfer_logged(0, 1'b1);
      xfer_logged(1, 1'b1);
      xfer_logged(2, 1'b1);
      begin
        // Every port is free, so all three slaves see stb one cycle after the masters
        @(negedge clk);
        @(negedge clk);
        check_mid($sformatf("parallel k%0d slave stb", k), 3'b111,
                  {s_stb[2], s_stb[1], s_stb[0]});
      end
    join
    for (int s = 0; s < 3; s++) begin
      if (hits[s] != hit_snap[s] + 1) begin
        abort_run($sformatf("Parallel round %0d: slave %0d did not take exactly one write",
                            k, s));
      end
    end
    fork
      xfer_logged(0, 1'b0);
      xfer_logged(1, 1'b0);
      xfer_logged(2, 1'b0);
    join
    for (int m = 0; m < 3; m++) begin
      check_data($sformatf("parallel k%0d m%0d", k, m), race_wdat[m], race_rdat[m]);
      last_gnt[(m + k) % 3] = m;
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    wbi_pkg::wb_data_t rd;
    wbi_pkg::wb_tid_t  tid;
    string             name;
    void'($urandom(32'h0414_b2ba));
    clk   = 1'b0;
    reset = 1'b1;
    for (int m = 0; m < 3; m++) begin
      m_cyc[m]  = 1'b0;
      m_stb[m]  = 1'b0;
      m_we[m]   = 1'b0;
      m_adr[m]  = '0;
      m_sel[m]  = '0;
      m_wdat[m] = '0;
    end
    build_table();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // Quiet bus right after reset
    check_mid("reset slave cyc", 3'b000, {s_cyc[2], s_cyc[1], s_cyc[0]});
    check_mid("reset slave stb", 3'b000, {s_stb[2], s_stb[1], s_stb[0]});
    check_mid("reset master ack", 3'b000, {m_ack[2], m_ack[1], m_ack[0]});
    // Decode and read back, one master at a time
    for (int i = 0; i < N_TBL; i++) begin
      name = $sformatf("table[%0d] m%0d %h", i, t_mst[i], t_adr[i]);
      take_snapshot();
      do_xfer(t_mst[i], t_we[i], t_adr[i], t_dat[i], rd);
      find_target(tid);
      check_tid(name, t_tid[i], tid);
      check_addr(name, t_sadr[i], last_adr[tid]);
      if (!t_we[i]) check_data(name, t_exp[i], rd);
      last_gnt[tid] = t_mst[i];
    end
    // Parallel rounds leave a different last owner on each slave
    for (int k = 0; k < 3; k++) begin
      parallel_round(k);
    end
    for (int t = 0; t < 3; t++) begin
      contend(t, 0);
      contend(t, 1);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== wb_interconnect.f ====
logic/wbi_pkg.sv
logic/wbi_master_port.sv
logic/wbi_rr_arbiter.sv
logic/wbi_slave_port.sv
logic/wb_interconnect.sv
dv/wbi_slave_model.sv
dv/tb_wb_interconnect.sv
